//--- sim.f
+incdir+testbench
common/huffPkg.sv
huffman/huffCtrl.sv
huffman/nodeTable.sv
huffman/minFinder.sv
huffman/codeBuilder.sv
huffman/codeSerializer.sv
huffman/huffTop.sv
testbench/tbHuff.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tbHuff -f sim.f \
    --Mdir obj_dir -o simHuff > build.log 2>&1 \
    && ./obj_dir/simHuff > sim.log 2>&1 \
    && ! grep -q "ERRORS FOUND" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- testbench/tbHuffModel.svh
// Huffman reference model and Galois LFSR for the encoder testbench, included inside tbHuff
`ifndef TBHUFFMODEL_SVH
`define TBHUFFMODEL_SVH

// expected out_code stream of one run
// nodes 0 to 7 are the leaves, merge n creates node 8 + n, so a node's index is its id
function automatic string modelStream(input logic mode,
                                      input logic [NumSymbols*WeightWidth-1:0] weights);
    int         nodeW [15];
    bit         alive [15];
    logic [7:0] leaves [15];
    string      code [NumSymbols];
    int         order [NumEmitted];
    int         first;
    int         second;
    int         bestKey;
    int         newNode;
    string      stream;
    for (int k = 0; k < 15; k++) begin
        nodeW[k]  = 0;
        alive[k]  = 1'b0;
        leaves[k] = '0;
    end
    for (int k = 0; k < NumSymbols; k++) begin
        nodeW[k]  = int'(weights[k*WeightWidth +: WeightWidth]);
        alive[k]  = 1'b1;
        leaves[k] = 8'(1 << k);
        code[k]   = "";
    end
    for (int n = 0; n < NumMerges; n++) begin
        // sort key is weight, then id
        first   = 0;
        bestKey = 1 << 30;
        for (int k = 0; k < 15; k++) begin
            if (alive[k] && (nodeW[k] * 16 + k) < bestKey) begin
                bestKey = nodeW[k] * 16 + k;
                first   = k;
            end
        end
        second  = 0;
        bestKey = 1 << 30;
        for (int k = 0; k < 15; k++) begin
            if (alive[k] && k != first && (nodeW[k] * 16 + k) < bestKey) begin
                bestKey = nodeW[k] * 16 + k;
                second  = k;
            end
        end
        // each merge sits one level closer to the root, so its bit goes in front
        for (int l = 0; l < NumSymbols; l++) begin
            if (leaves[first][l]) begin
                code[l] = {"1", code[l]};
            end else if (leaves[second][l]) begin
                code[l] = {"0", code[l]};
            end
        end
        newNode         = NumSymbols + n;
        nodeW[newNode]  = nodeW[first] + nodeW[second];
        leaves[newNode] = leaves[first] | leaves[second];
        alive[newNode]  = 1'b1;
        alive[first]    = 1'b0;
        alive[second]   = 1'b0;
    end
    // mode 1 sends I C L A B, mode 0 sends I L O V E
    if (mode) begin
        order = '{4, 2, 5, 0, 1};
    end else begin
        order = '{4, 5, 6, 7, 3};
    end
    stream = "";
    for (int j = 0; j < NumEmitted; j++) begin
        stream = {stream, code[order[j]]};
    end
    return stream;
endfunction

// one step of a 32-bit Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
endfunction

`endif

//--- testbench/tbHuff.sv
// testbench for the Huffman encoder, runs a table of weight sets through huffTop against a model
`timescale 1ns/10ps

module tbHuff;
    import huffPkg::*;

    localparam int NumTests      = 14;
    localparam int TimeoutCycles = NumTests * 120;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic [WeightWidth-1:0] in_weight;
    logic                   out_mode;
    logic                   out_valid;
    logic                   out_code;

    // stimulus table, expected streams filled in from the model
    logic                              tblMode [NumTests];
    logic [NumSymbols*WeightWidth-1:0] tblWeights [NumTests];
    string                             tblExpect [NumTests];

    logic [31:0] lfsrState;
    int          cycleCount = 0;
    int          passCount;
    int          failCount;

    `include "tbHuffModel.svh"

    huffTop u_huffTop (
        .clk, .rst_n, .in_valid, .in_weight, .out_mode, .out_valid, .out_code
    );

    always #20 clk = ~clk;

    // ==================================================
    // watchdog
    // ==================================================
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TimeoutCycles) begin
            $display("timeout after %0d cycles, the encoder never finished a stream",
                     TimeoutCycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // weights listed in symbol order A B C E I L O V
    function automatic logic [NumSymbols*WeightWidth-1:0] packWeights(
        input logic [2:0] a, input logic [2:0] b, input logic [2:0] c, input logic [2:0] e,
        input logic [2:0] i, input logic [2:0] l, input logic [2:0] o, input logic [2:0] v
    );
        return {v, o, l, i, e, c, b, a};
    endfunction

    task automatic setRow(input int t, input logic mode,
                          input logic [NumSymbols*WeightWidth-1:0] weights);
        tblMode[t]    = mode;
        tblWeights[t] = weights;
        tblExpect[t]  = modelStream(mode, weights);
    endtask

    task automatic drawWeights(output logic [NumSymbols*WeightWidth-1:0] weights);
        for (int b = 0; b < NumSymbols * WeightWidth; b++) begin
            weights[b] = lfsrState[0];
            lfsrState  = lfsrNext(lfsrState);
        end
    endtask

    task automatic buildTable();
        logic [NumSymbols*WeightWidth-1:0] w;
        w = packWeights(3'd5, 3'd1, 3'd7, 3'd2, 3'd6, 3'd0, 3'd3, 3'd4);
        setRow(0, 1'b0, w);
        setRow(1, 1'b1, w);
        // ties resolved by node id only
        setRow(2, 1'b0, packWeights(3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3));
        setRow(3, 1'b1, packWeights(3'd7, 3'd7, 3'd7, 3'd7, 3'd7, 3'd7, 3'd7, 3'd7));
        setRow(4, 1'b1, packWeights(3'd0, 3'd0, 3'd4, 3'd0, 3'd2, 3'd0, 3'd7, 3'd1));
        setRow(5, 1'b0, packWeights(3'd0, 3'd3, 3'd0, 3'd0, 3'd0, 3'd5, 3'd0, 3'd2));
        for (int t = 6; t < NumTests; t++) begin
            drawWeights(w);
            setRow(t, t[0], w);
        end
    endtask

    // ==================================================
    // checks
    // ==================================================
    task automatic checkIdle();
        int errors;
        errors = 0;
        repeat (6) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("FAIL t=%0t signal out_valid expected 0 got %b", $time, out_valid);
                errors++;
            end
            if (out_code !== 1'b0) begin
                $display("FAIL t=%0t signal out_code expected 0 got %b", $time, out_code);
                errors++;
            end
        end
        if (errors == 0) begin
            $display("idle test passed, outputs low after reset");
            passCount++;
        end else begin
            failCount++;
        end
    endtask

    task automatic applyWeights(input int t);
        for (int s = 0; s < NumSymbols; s++) begin
            @(posedge clk);
            in_valid  <= 1'b1;
            in_weight <= tblWeights[t][s*WeightWidth +: WeightWidth];
            out_mode  <= tblMode[t];
        end
        @(posedge clk);
        in_valid  <= 1'b0;
        in_weight <= '0;
        out_mode  <= 1'b0;
    endtask

    // sampled on the falling edge, away from the DUT's register updates
    task automatic collectStream(output string bits, output logic gap);
        bits = "";
        gap  = 1'b0;
        @(negedge clk);
        while (!out_valid) begin
            @(negedge clk);
        end
        while (out_valid) begin
            if (out_code) begin
                bits = {bits, "1"};
            end else begin
                bits = {bits, "0"};
            end
            @(negedge clk);
        end
        // out_valid must not come back right after the stream
        repeat (2) begin
            @(negedge clk);
            if (out_valid) begin
                gap = 1'b1;
            end
        end
    endtask

    task automatic checkRun(input int t);
        string got;
        logic  gap;
        applyWeights(t);
        collectStream(got, gap);
        if (gap) begin
            $display("test %0d failed: out_valid dropped and rose again within one stream", t);
            failCount++;
        end else if (got.len() != tblExpect[t].len()) begin
            $display("test %0d failed: out_code stream has %0d bits, the model expects %0d",
                     t, got.len(), tblExpect[t].len());
            failCount++;
        end else if (got != tblExpect[t]) begin
            $display("FAIL t=%0t test %0d signal out_code expected %s got %s",
                     $time, t, tblExpect[t], got);
            failCount++;
        end else begin
            $display("test %0d mode %0d passed, %0d bits", t, tblMode[t], got.len());
            passCount++;
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_weight = '0;
        out_mode  = 1'b0;
        passCount = 0;
        failCount = 0;
        lfsrState = 32'h891acac7;
        buildTable();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        checkIdle();
        // runs follow each other with no reset in between
        for (int t = 0; t < NumTests; t++) begin
            checkRun(t);
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- huffman/huffTop.sv
// top level of the eight-symbol Huffman encoder, connects control, tables, scan and output
`timescale 1ns/10ps

module huffTop (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic [huffPkg::WeightWidth-1:0] in_weight,
    input  logic                            out_mode,
    output logic                            out_valid,
    output logic                            out_code
);
    import huffPkg::*;

    // ==================================================
    // control strobes
    // ==================================================
    logic                    loadEn;
    logic [SlotWidth-1:0]    loadSlot;
    logic                    scanStart;
    logic                    scanDone;
    logic                    mergeEn;
    logic                    emitStart;
    logic                    emitDone;
    logic                    modeSel;

    // table contents
    logic [NodeWeightWidth-1:0] nodeWeight [NumSymbols];
    logic [NodeIdWidth-1:0]     nodeId [NumSymbols];
    logic                       nodeLive [NumSymbols];
    logic [SlotWidth-1:0]       minSlotA;
    logic [SlotWidth-1:0]       minSlotB;
    logic [MaxCodeLen-1:0]      leafCode [NumSymbols];
    logic [CodeLenWidth-1:0]    leafLen [NumSymbols];

    huffCtrl u_huffCtrl (
        .clk, .rst_n, .in_valid, .out_mode, .scanDone, .emitDone,
        .loadEn, .loadSlot, .scanStart, .mergeEn, .emitStart, .modeSel
    );

    nodeTable u_nodeTable (
        .clk, .rst_n, .loadEn, .loadSlot, .in_weight, .mergeEn,
        .minSlotA, .minSlotB, .nodeWeight, .nodeId, .nodeLive
    );

    minFinder u_minFinder (
        .clk, .rst_n, .scanStart, .nodeWeight, .nodeId, .nodeLive,
        .scanDone, .minSlotA, .minSlotB
    );

    codeBuilder u_codeBuilder (
        .clk, .rst_n, .loadEn, .loadSlot, .mergeEn, .minSlotA, .minSlotB,
        .leafCode, .leafLen
    );

    codeSerializer u_codeSerializer (
        .clk, .rst_n, .emitStart, .modeSel, .leafCode, .leafLen,
        .out_valid, .out_code, .emitDone
    );

endmodule

//--- huffman/codeSerializer.sv
// serial output stage, sends the codes of the five selected symbols one bit per cycle
`timescale 1ns/10ps

module codeSerializer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             emitStart,
    input  logic                             modeSel,
    input  logic [huffPkg::MaxCodeLen-1:0]   leafCode [huffPkg::NumSymbols],
    input  logic [huffPkg::CodeLenWidth-1:0] leafLen [huffPkg::NumSymbols],
    output logic                             out_valid,
    output logic                             out_code,
    output logic                             emitDone
);
    import huffPkg::*;

    logic                    sending;
    logic                    active;
    logic                    lastBit;
    logic                    lastSym;
    logic [SlotWidth-1:0]    symIdx;
    logic [SlotWidth-1:0]    curIdx;
    logic [SlotWidth-1:0]    nextIdx;
    logic [CodeLenWidth-1:0] bitIdx;
    logic [CodeLenWidth-1:0] curBit;
    symbol_t                 curSym;
    symbol_t                 nextSym;

    function automatic symbol_t orderAt(input logic mode, input logic [SlotWidth-1:0] idx);
        return mode ? emitOrderMode1[idx] : emitOrderMode0[idx];
    endfunction

    // ==================================================
    // current symbol and bit
    // ==================================================
    assign active  = emitStart | sending;
    assign curIdx  = emitStart ? '0 : symIdx;
    assign curSym  = orderAt(modeSel, curIdx);
    assign curBit  = emitStart ? leafLen[curSym] - 1'b1 : bitIdx;
    assign lastBit = (curBit == '0);
    assign lastSym = (curIdx == SlotWidth'(NumEmitted - 1));
    assign nextIdx = lastSym ? '0 : curIdx + 1'b1;
    assign nextSym = orderAt(modeSel, nextIdx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sending   <= 1'b0;
            symIdx    <= '0;
            bitIdx    <= '0;
            out_valid <= 1'b0;
            out_code  <= 1'b0;
            emitDone  <= 1'b0;
        end else begin
            out_valid <= active;
            out_code  <= active & leafCode[curSym][curBit];
            // high together with the final bit
            emitDone  <= active & lastBit & lastSym;
            if (active) begin
                if (!lastBit) begin
                    sending <= 1'b1;
                    symIdx  <= curIdx;
                    bitIdx  <= curBit - 1'b1;
                end else if (!lastSym) begin
                    sending <= 1'b1;
                    symIdx  <= nextIdx;
                    bitIdx  <= leafLen[nextSym] - 1'b1;
                end else begin
                    sending <= 1'b0;
                end
            end
        end
    end

endmodule

//--- huffman/codeBuilder.sv
// per-leaf code bits, length and owning root slot, extended by one bit at every merge
`timescale 1ns/10ps

module codeBuilder (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             loadEn,
    input  logic [huffPkg::SlotWidth-1:0]    loadSlot,
    input  logic                             mergeEn,
    input  logic [huffPkg::SlotWidth-1:0]    minSlotA,
    input  logic [huffPkg::SlotWidth-1:0]    minSlotB,
    output logic [huffPkg::MaxCodeLen-1:0]   leafCode [huffPkg::NumSymbols],
    output logic [huffPkg::CodeLenWidth-1:0] leafLen [huffPkg::NumSymbols]
);
    import huffPkg::*;

    // root slot that currently holds each leaf
    logic [SlotWidth-1:0] leafOwner [NumSymbols];

    // ==================================================
    // lengths and ownership
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leafLen   <= '{default: '0};
            leafOwner <= '{default: '0};
        end else if (loadEn) begin
            leafLen[loadSlot]   <= '0;
            leafOwner[loadSlot] <= loadSlot;
        end else if (mergeEn) begin
            for (int s = 0; s < NumSymbols; s++) begin
                if (leafOwner[s] == minSlotA || leafOwner[s] == minSlotB) begin
                    leafLen[s] <= leafLen[s] + 1'b1;
                end
                // leaves of the second root move under slot A
                if (leafOwner[s] == minSlotB) begin
                    leafOwner[s] <= minSlotA;
                end
            end
        end
    end

    // new bit lands above the existing ones, so the root bit ends up on top
    always_ff @(posedge clk) begin
        if (loadEn) begin
            leafCode[loadSlot] <= '0;
        end else if (mergeEn) begin
            for (int s = 0; s < NumSymbols; s++) begin
                if (leafOwner[s] == minSlotA) begin
                    leafCode[s][leafLen[s]] <= 1'b1;
                end else if (leafOwner[s] == minSlotB) begin
                    leafCode[s][leafLen[s]] <= 1'b0;
                end
            end
        end
    end

endmodule

//--- huffman/minFinder.sv
// sequential scan over the root table, one slot per cycle, finding the two lightest live roots
`timescale 1ns/10ps

module minFinder (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                scanStart,
    input  logic [huffPkg::NodeWeightWidth-1:0] nodeWeight [huffPkg::NumSymbols],
    input  logic [huffPkg::NodeIdWidth-1:0]     nodeId [huffPkg::NumSymbols],
    input  logic                                nodeLive [huffPkg::NumSymbols],
    output logic                                scanDone,
    output logic [huffPkg::SlotWidth-1:0]       minSlotA,
    output logic [huffPkg::SlotWidth-1:0]       minSlotB
);
    import huffPkg::*;

    logic                 scanning;
    logic                 stepEn;
    logic [SlotWidth-1:0] scanIdx;
    logic [SlotWidth-1:0] curSlot;
    logic                 bestValid;
    logic                 secondValid;
    logic                 baseBestValid;
    logic                 baseSecondValid;
    logic                 nextBestValid;
    logic                 nextSecondValid;
    logic [SlotWidth-1:0] nextBest;
    logic [SlotWidth-1:0] nextSecond;

    // weight first, node id breaks ties
    function automatic logic lighter(
        input logic [NodeWeightWidth-1:0] wa,
        input logic [NodeIdWidth-1:0]     ia,
        input logic [NodeWeightWidth-1:0] wb,
        input logic [NodeIdWidth-1:0]     ib
    );
        return (wa < wb) || ((wa == wb) && (ia < ib));
    endfunction

    // slot 0 is examined in the scanStart cycle itself
    assign stepEn          = scanStart | scanning;
    assign curSlot         = scanStart ? '0 : scanIdx;
    assign baseBestValid   = scanStart ? 1'b0 : bestValid;
    assign baseSecondValid = scanStart ? 1'b0 : secondValid;
    assign scanDone        = scanning && (scanIdx == SlotWidth'(NumSymbols - 1));

    always_comb begin
        nextBest        = minSlotA;
        nextSecond      = minSlotB;
        nextBestValid   = baseBestValid;
        nextSecondValid = baseSecondValid;
        if (nodeLive[curSlot]) begin
            if (!baseBestValid || lighter(nodeWeight[curSlot], nodeId[curSlot],
                                          nodeWeight[minSlotA], nodeId[minSlotA])) begin
                // old best drops to second place
                nextSecond      = minSlotA;
                nextSecondValid = baseBestValid;
                nextBest        = curSlot;
                nextBestValid   = 1'b1;
            end else if (!baseSecondValid || lighter(nodeWeight[curSlot], nodeId[curSlot],
                                                     nodeWeight[minSlotB], nodeId[minSlotB])) begin
                nextSecond      = curSlot;
                nextSecondValid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scanning    <= 1'b0;
            scanIdx     <= '0;
            bestValid   <= 1'b0;
            secondValid <= 1'b0;
            minSlotA    <= '0;
            minSlotB    <= '0;
        end else if (stepEn) begin
            scanning    <= (curSlot != SlotWidth'(NumSymbols - 1));
            scanIdx     <= curSlot + 1'b1;
            bestValid   <= nextBestValid;
            secondValid <= nextSecondValid;
            minSlotA    <= nextBest;
            minSlotB    <= nextSecond;
        end
    end

endmodule

//--- huffman/nodeTable.sv
// table of current tree roots, one slot per leaf; a merge folds slot B into slot A
`timescale 1ns/10ps

module nodeTable (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                loadEn,
    input  logic [huffPkg::SlotWidth-1:0]       loadSlot,
    input  logic [huffPkg::WeightWidth-1:0]     in_weight,
    input  logic                                mergeEn,
    input  logic [huffPkg::SlotWidth-1:0]       minSlotA,
    input  logic [huffPkg::SlotWidth-1:0]       minSlotB,
    output logic [huffPkg::NodeWeightWidth-1:0] nodeWeight [huffPkg::NumSymbols],
    output logic [huffPkg::NodeIdWidth-1:0]     nodeId [huffPkg::NumSymbols],
    output logic                                nodeLive [huffPkg::NumSymbols]
);
    import huffPkg::*;

    logic [NodeIdWidth-1:0]     nextId;
    logic [NodeWeightWidth-1:0] mergedWeight;

    assign mergedWeight = nodeWeight[minSlotA] + nodeWeight[minSlotB];

    // ==================================================
    // live flags and merged node ids
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nextId   <= NodeIdWidth'(NumSymbols);
            nodeLive <= '{default: 1'b0};
        end else if (loadEn) begin
            // each new run numbers its merges from 8 again
            nextId             <= NodeIdWidth'(NumSymbols);
            nodeLive[loadSlot] <= 1'b1;
        end else if (mergeEn) begin
            nextId             <= nextId + 1'b1;
            nodeLive[minSlotB] <= 1'b0;
        end
    end

    // weight and id per slot
    always_ff @(posedge clk) begin
        if (loadEn) begin
            nodeWeight[loadSlot] <= NodeWeightWidth'(in_weight);
            nodeId[loadSlot]     <= NodeIdWidth'(loadSlot);
        end else if (mergeEn) begin
            // slot A becomes the new root
            nodeWeight[minSlotA] <= mergedWeight;
            nodeId[minSlotA]     <= nextId;
        end
    end

endmodule

//--- huffman/huffCtrl.sv
// control FSM of the Huffman encoder, sequences weight load, seven scan/merge rounds and emit
`timescale 1ns/10ps

module huffCtrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic                          out_mode,
    input  logic                          scanDone,
    input  logic                          emitDone,
    output logic                          loadEn,
    output logic [huffPkg::SlotWidth-1:0] loadSlot,
    output logic                          scanStart,
    output logic                          mergeEn,
    output logic                          emitStart,
    output logic                          modeSel
);
    import huffPkg::*;

    ctrlState_t           state;
    logic [SlotWidth-1:0] loadCnt;
    logic [SlotWidth-1:0] mergeCnt;

    // weights are written in the same cycle they arrive
    assign loadEn   = in_valid && (state == IDLE || state == LOAD);
    assign loadSlot = loadCnt;
    assign mergeEn  = (state == MERGE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            loadCnt   <= '0;
            mergeCnt  <= '0;
            modeSel   <= 1'b0;
            scanStart <= 1'b0;
            emitStart <= 1'b0;
        end else begin
            scanStart <= 1'b0;
            emitStart <= 1'b0;
            case (state)
                IDLE: begin
                    // first weight, slot 0, mode sampled here only
                    if (in_valid) begin
                        modeSel <= out_mode;
                        loadCnt <= SlotWidth'(1);
                        state   <= LOAD;
                    end
                end
                LOAD: begin
                    if (in_valid) begin
                        if (loadCnt == SlotWidth'(NumSymbols - 1)) begin
                            loadCnt   <= '0;
                            mergeCnt  <= '0;
                            scanStart <= 1'b1;
                            state     <= SCAN;
                        end else begin
                            loadCnt <= loadCnt + 1'b1;
                        end
                    end
                end
                SCAN: begin
                    if (scanDone) begin
                        state <= MERGE;
                    end
                end
                MERGE: begin
                    // tables update at the end of this cycle
                    if (mergeCnt == SlotWidth'(NumMerges - 1)) begin
                        emitStart <= 1'b1;
                        state     <= EMIT;
                    end else begin
                        mergeCnt  <= mergeCnt + 1'b1;
                        scanStart <= 1'b1;
                        state     <= SCAN;
                    end
                end
                EMIT: begin
                    if (emitDone) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- common/huffPkg.sv
// shared sizes, enums and emit order tables, imported by every Huffman encoder module
package huffPkg;

    // ==================================================
    // sizes
    // ==================================================
    localparam int NumSymbols      = 8;
    localparam int WeightWidth     = 3;
    // eight leaves of weight 7 sum to 56
    localparam int NodeWeightWidth = 6;
    localparam int SlotWidth       = 3;
    // leaves 0 to 7, merged nodes 8 to 14
    localparam int NodeIdWidth     = 4;
    localparam int MaxCodeLen      = 7;
    localparam int CodeLenWidth    = 3;
    localparam int NumEmitted      = 5;
    localparam int NumMerges       = 7;

    // ==================================================
    // enums
    // ==================================================
    // leaf order, also the leaf node ids
    typedef enum logic [SlotWidth-1:0] {
        A = 0, B, C, E, I, L, O, V
    } symbol_t;

    typedef enum logic [2:0] {
        IDLE, LOAD, SCAN, MERGE, EMIT
    } ctrlState_t;

    // symbols sent per run, first entry goes out first
    localparam symbol_t emitOrderMode0 [NumEmitted] = '{I, L, O, V, E};
    localparam symbol_t emitOrderMode1 [NumEmitted] = '{I, C, L, A, B};

endpackage
